// ==== design/rn_settings.svh ====
/*
  Sizing constants for the rename slice. RN_PREGS and RN_ROB_DEPTH must be
  powers of two. RN_PREGS must exceed RN_AREGS by at least RN_LANES so that a
  full group can always be renamed once commits drain.
*/
`ifndef RN_SETTINGS_SVH
`define RN_SETTINGS_SVH

// Instructions renamed per cycle
`define RN_LANES 4

// Architectural and physical register file sizes
`define RN_AREGS 32
`define RN_PREGS 64

// Reorder buffer entries, only pointers and occupancy are modelled
`define RN_ROB_DEPTH 16

// Address carried by the reset record
`define RN_RESET_PC 32'hFFFC0000

`endif

// ==== design/rn_pkg.sv ====
/*
  Types shared by the rename slice. Widths follow rn_settings.svh.
  The pipeline record carries no opcode or operand payload.
*/
`include "rn_settings.svh"

package rn_pkg;

	// ======================================================================
	// Register and tag numbers
	// ======================================================================

	typedef logic [$clog2(`RN_AREGS)-1:0] areg_t;
	typedef logic [$clog2(`RN_PREGS)-1:0] preg_t;
	typedef logic [$clog2(`RN_ROB_DEPTH)-1:0] rob_tag_t;

	// ======================================================================
	// Per-lane pipeline record
	// ======================================================================

	// One renamed instruction as it moves from rename into the queue stage
	typedef struct packed {
		logic        v;
		logic [31:0] pc;
		// Architectural registers as decoded
		areg_t       ard;
		areg_t       ars1;
		areg_t       ars2;
		// Physical registers after renaming
		preg_t       pd;
		preg_t       ps1;
		preg_t       ps2;
		// Previous mapping of ard, returned to the free list at commit
		preg_t       pd_old;
		rob_tag_t    tag;
		logic        nop;
	} pipe_reg_t;

	// Record loaded into pipeline registers at reset
	// It is an invalid no-operation that points at the reset address
	function automatic pipe_reg_t nop_rec();
		pipe_reg_t r;
		r = '0;
		r.pc = `RN_RESET_PC;
		r.nop = 1'b1;
		return r;
	endfunction

endpackage

// ==== design/free_list.sv ====
/*
  Circular queue of free physical registers. Offers the RN_LANES entries at
  the head; the caller must not pop more than free_count. Pushes must never
  overflow, which holds as long as only unmapped registers are returned.
*/
`timescale 1ns/1ps
`include "rn_settings.svh"

module free_list import rn_pkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	output preg_t                 alloc_preg [`RN_LANES],
	output logic [6:0]            free_count,
	input  logic [2:0]            alloc_count,
	input  logic [`RN_LANES-1:0]  push_v,
	input  preg_t                 push_preg [`RN_LANES]
);

	localparam int PTR_W = $clog2(`RN_PREGS);

	// Registers 0 to RN_AREGS-1 start out mapped, the rest start out free
	localparam int INIT_FREE = `RN_PREGS - `RN_AREGS;

	preg_t            fl_mem [`RN_PREGS];
	logic [PTR_W-1:0] head;
	logic [PTR_W-1:0] tail;
	logic [6:0]       cnt;

	// Compacted write slot for each push lane, relative to the tail
	logic [2:0]       push_ofs [`RN_LANES];
	logic [2:0]       push_count;

	// ======================================================================
	// Push compaction
	// ======================================================================

	// Valid push lanes land at consecutive slots in lane order
	always_comb begin
		push_count = '0;
		for (int i = 0; i < `RN_LANES; i++) begin
			push_ofs[i] = push_count;
			push_count = push_count + 3'(push_v[i]);
		end
	end

	// The next entries in queue order, whether or not they are popped
	always_comb begin
		for (int i = 0; i < `RN_LANES; i++)
			alloc_preg[i] = fl_mem[head + PTR_W'(i)];
	end

	// ======================================================================
	// Queue state
	// ======================================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			head <= '0;
			tail <= PTR_W'(INIT_FREE);
			cnt  <= 7'(INIT_FREE);
			// Fill the first slots with the registers above the identity map
			for (int i = 0; i < INIT_FREE; i++)
				fl_mem[i] <= preg_t'(`RN_AREGS + i);
		end else begin
			for (int i = 0; i < `RN_LANES; i++) begin
				if (push_v[i])
					fl_mem[tail + PTR_W'(push_ofs[i])] <= push_preg[i];
			end
			// Pops and pushes in the same cycle both take effect
			head <= head + PTR_W'(alloc_count);
			tail <= tail + PTR_W'(push_count);
			cnt  <= cnt + 7'(push_count) - 7'(alloc_count);
		end
	end

	assign free_count = cnt;

endmodule

// ==== design/rob_alloc.sv ====
/*
  Reorder-buffer pointer tracking only; no entry payload is stored.
  Commits must not exceed the occupancy and allocations must not exceed
  rob_free. Both pointers carry one extra wrap bit.
*/
`timescale 1ns/1ps
`include "rn_settings.svh"

module rob_alloc import rn_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic [2:0] alloc_count,
	input  logic [2:0] commit_count,
	output rob_tag_t   tail_tag,
	output logic [4:0] rob_free,
	output logic [4:0] rob_count
);

	localparam int TAG_W = $clog2(`RN_ROB_DEPTH);

	// One bit wider than a tag so that full and empty differ
	logic [TAG_W:0] head;
	logic [TAG_W:0] tail;
	logic [TAG_W:0] occ;

	// ======================================================================
	// Pointer update
	// ======================================================================

	// Allocation moves the tail and commit moves the head
	// Both may happen in the same cycle
	always_ff @(posedge clk) begin
		if (rst) begin
			head <= '0;
			tail <= '0;
		end else begin
			tail <= tail + (TAG_W+1)'(alloc_count);
			head <= head + (TAG_W+1)'(commit_count);
		end
	end

	// Occupancy falls out of the pointer distance including the wrap bit
	assign occ = tail - head;

	// ======================================================================
	// Outputs
	// ======================================================================

	// The first valid lane of the next group gets the tail entry
	assign tail_tag = tail[TAG_W-1:0];

	assign rob_count = 5'(occ);

	// Entries still available for allocation
	assign rob_free = 5'(`RN_ROB_DEPTH) - 5'(occ);

endmodule

// ==== design/rename_map.sv ====
/*
  Alias table and rename-stage register. Lanes of a group are renamed as if
  in program order, lane 0 first. Architectural register 0 maps to physical
  register 0 and never takes a new register. No checkpoint or recovery.
*/
`timescale 1ns/1ps
`include "rn_settings.svh"

module rename_map import rn_pkg::*; (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 adv,
	input  logic                 accept,
	input  logic [`RN_LANES-1:0] in_v,
	input  logic [31:0]          in_pc [`RN_LANES],
	input  areg_t                in_rd [`RN_LANES],
	input  areg_t                in_rs1 [`RN_LANES],
	input  areg_t                in_rs2 [`RN_LANES],
	input  preg_t                alloc_preg [`RN_LANES],
	input  rob_tag_t             tail_tag,
	output logic [2:0]           alloc_count,
	output logic [2:0]           need_pregs,
	output logic [2:0]           need_tags,
	output pipe_reg_t            ren_rec [`RN_LANES]
);

	localparam int LANE_W = $clog2(`RN_LANES);

	// Architectural to physical map, the committed and speculative view
	preg_t            amap [`RN_AREGS];

	// Lanes that write a real destination and so take a free register
	logic [`RN_LANES-1:0] wr;
	pipe_reg_t        rec [`RN_LANES];
	logic [2:0]       npreg;
	logic [2:0]       ntag;

	// ======================================================================
	// Group rename
	// ======================================================================

	always_comb begin
		npreg = '0;
		ntag  = '0;
		for (int i = 0; i < `RN_LANES; i++) begin
			wr[i] = in_v[i] && (in_rd[i] != '0);
			rec[i] = '0;
			// A group that is not taken leaves invalid slots behind
			rec[i].v    = in_v[i] && accept;
			rec[i].pc   = in_pc[i];
			rec[i].ard  = in_rd[i];
			rec[i].ars1 = in_rs1[i];
			rec[i].ars2 = in_rs2[i];
			rec[i].tag  = tail_tag + rob_tag_t'(ntag);
			// Table lookups first
			rec[i].ps1    = amap[in_rs1[i]];
			rec[i].ps2    = amap[in_rs2[i]];
			rec[i].pd_old = amap[in_rd[i]];
			// Then bypass from earlier lanes, the latest writer wins
			for (int j = 0; j < i; j++) begin
				if (wr[j] && in_rd[j] == in_rs1[i])
					rec[i].ps1 = rec[j].pd;
				if (wr[j] && in_rd[j] == in_rs2[i])
					rec[i].ps2 = rec[j].pd;
				if (wr[j] && in_rd[j] == in_rd[i])
					rec[i].pd_old = rec[j].pd;
			end
			// New destinations come off the free list in lane order
			rec[i].pd = wr[i] ? alloc_preg[npreg[LANE_W-1:0]] : '0;
			npreg = npreg + 3'(wr[i]);
			ntag  = ntag + 3'(in_v[i]);
		end
	end

	assign need_pregs = npreg;
	assign need_tags  = ntag;

	// Only an accepted group actually consumes free registers
	assign alloc_count = accept ? npreg : 3'd0;

	// ======================================================================
	// Table update and stage register
	// ======================================================================

	// Nonblocking writes in lane order leave the last writer of each register
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int r = 0; r < `RN_AREGS; r++)
				amap[r] <= preg_t'(r);
		end else if (accept) begin
			for (int i = 0; i < `RN_LANES; i++) begin
				if (wr[i])
					amap[in_rd[i]] <= rec[i].pd;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `RN_LANES; i++)
				ren_rec[i] <= nop_rec();
		end else if (adv) begin
			for (int i = 0; i < `RN_LANES; i++)
				ren_rec[i] <= rec[i];
		end
	end

endmodule

// ==== design/pipeline_que.sv ====
/*
  Queue stage beside the reorder-buffer write. Each lane keeps the last valid
  record it saw so later stages can bypass from it; invalid slots are skipped.
*/
`timescale 1ns/1ps
`include "rn_settings.svh"

module pipeline_que import rn_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  logic      en,
	input  pipe_reg_t ren_rec [`RN_LANES],
	input  logic      ucode_ren,
	output pipe_reg_t que_rec [`RN_LANES],
	output logic      que_ucode
);

	// ======================================================================
	// Per-lane record hold
	// ======================================================================

	// Each lane is independent, one lane may update while its neighbour holds
	genvar g;
	generate
		for (g = 0; g < `RN_LANES; g++) begin : g_lane
			always_ff @(posedge clk) begin
				if (rst) begin
					que_rec[g] <= nop_rec();
				end else if (en) begin
					// Mirrors what the reorder buffer receives for this slot
					if (ren_rec[g].v)
						que_rec[g] <= ren_rec[g];
				end
			end
		end
	endgenerate

	// ======================================================================
	// Micro-code flag
	// ======================================================================

	// Unlike the records this follows its input on every enabled cycle
	always_ff @(posedge clk) begin
		if (rst)
			que_ucode <= 1'b0;
		else if (en)
			que_ucode <= ucode_ren;
	end

endmodule

// ==== design/rename_top.sv ====
/*
  Four-lane rename slice. A group is taken when in_ready is high and any
  in_v is set. Commits must be in order and are applied even under stall.
*/
`timescale 1ns/1ps
`include "rn_settings.svh"

module rename_top import rn_pkg::*; (
	input  logic                 clk,
	input  logic                 rst,
	input  logic [`RN_LANES-1:0] in_v,
	input  logic [31:0]          in_pc [`RN_LANES],
	input  areg_t                in_rd [`RN_LANES],
	input  areg_t                in_rs1 [`RN_LANES],
	input  areg_t                in_rs2 [`RN_LANES],
	input  logic                 ucode_active,
	input  logic                 dispatch_stall,
	input  logic [`RN_LANES-1:0] commit_v,
	input  preg_t                commit_old_pd [`RN_LANES],
	output logic                 in_ready,
	output pipe_reg_t            que_rec [`RN_LANES],
	output logic                 que_ucode,
	output logic [4:0]           rob_count
);

	preg_t                alloc_preg [`RN_LANES];
	logic [6:0]           free_count;
	logic [2:0]           fl_pops;
	logic [2:0]           need_pregs;
	logic [2:0]           need_tags;
	rob_tag_t             tail_tag;
	logic [4:0]           rob_free;
	logic [2:0]           commit_count;
	logic [`RN_LANES-1:0] push_v;
	pipe_reg_t            ren_rec [`RN_LANES];
	logic                 ucode_ren;
	logic                 adv;
	logic                 accept;

	// ======================================================================
	// Accept and stall control
	// ======================================================================

	assign adv = !dispatch_stall;

	// Enough registers and reorder-buffer entries for the whole group
	assign in_ready = adv && (free_count >= 7'(need_pregs)) && (rob_free >= 5'(need_tags));
	assign accept = in_ready && (|in_v);

	// Register 0 is never handed out, so it is never taken back
	always_comb begin
		commit_count = '0;
		for (int i = 0; i < `RN_LANES; i++) begin
			push_v[i] = commit_v[i] && (commit_old_pd[i] != '0);
			commit_count = commit_count + 3'(commit_v[i]);
		end
	end

	// Rename-stage copy of the micro-code flag
	always_ff @(posedge clk) begin
		if (rst)
			ucode_ren <= 1'b0;
		else if (adv)
			ucode_ren <= ucode_active;
	end

	// ======================================================================
	// Blocks
	// ======================================================================

	free_list u_free_list (
		.clk         (clk),
		.rst         (rst),
		.alloc_preg  (alloc_preg),
		.free_count  (free_count),
		.alloc_count (fl_pops),
		.push_v      (push_v),
		.push_preg   (commit_old_pd)
	);

	// Tags are consumed only by an accepted group
	rob_alloc u_rob_alloc (
		.clk          (clk),
		.rst          (rst),
		.alloc_count  (accept ? need_tags : 3'd0),
		.commit_count (commit_count),
		.tail_tag     (tail_tag),
		.rob_free     (rob_free),
		.rob_count    (rob_count)
	);

	rename_map u_rename_map (
		.clk         (clk),
		.rst         (rst),
		.adv         (adv),
		.accept      (accept),
		.in_v        (in_v),
		.in_pc       (in_pc),
		.in_rd       (in_rd),
		.in_rs1      (in_rs1),
		.in_rs2      (in_rs2),
		.alloc_preg  (alloc_preg),
		.tail_tag    (tail_tag),
		.alloc_count (fl_pops),
		.need_pregs  (need_pregs),
		.need_tags   (need_tags),
		.ren_rec     (ren_rec)
	);

	pipeline_que u_pipeline_que (
		.clk       (clk),
		.rst       (rst),
		.en        (adv),
		.ren_rec   (ren_rec),
		.ucode_ren (ucode_ren),
		.que_rec   (que_rec),
		.que_ucode (que_ucode)
	);

endmodule

// ==== sim/rename_tb.sv ====
/*
  Testbench for rename_top. A reference model keeps its own alias table,
  free-list queue, tail and in-flight old registers; results checked at negedge.
*/
`timescale 1ns/1ps
`include "rn_settings.svh"

module rename_tb import rn_pkg::*; ();

	logic                 clk;
	logic                 rst;
	logic [`RN_LANES-1:0] in_v;
	logic [31:0]          in_pc [`RN_LANES];
	areg_t                in_rd [`RN_LANES];
	areg_t                in_rs1 [`RN_LANES];
	areg_t                in_rs2 [`RN_LANES];
	logic                 ucode_active;
	logic                 dispatch_stall;
	logic [`RN_LANES-1:0] commit_v;
	preg_t                commit_old_pd [`RN_LANES];
	logic                 in_ready;
	pipe_reg_t            que_rec [`RN_LANES];
	logic                 que_ucode;
	logic [4:0]           rob_count;

	// Reference state
	preg_t     amap [`RN_AREGS];
	preg_t     fl_q [$];
	preg_t     rob_q [$];
	preg_t     held_q [$];
	rob_tag_t  tail;
	pipe_reg_t ren_exp [`RN_LANES];
	pipe_reg_t que_exp [`RN_LANES];
	logic      ren_uc;
	logic      que_uc_exp;
	int        mismatches;
	int        failures;

	rename_top dut_i (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ======================================================================
	// Reference model
	// ======================================================================

	// Expected record left by reset
	function automatic pipe_reg_t reset_rec();
		pipe_reg_t r;
		r = '0;
		r.pc = 32'hFFFC0000;
		r.nop = 1'b1;
		return r;
	endfunction

	// Whether the group now on the inputs fits in free registers and ROB entries
	function automatic logic exp_ready();
		int need;
		int nv;
		need = 0;
		nv = 0;
		for (int i = 0; i < `RN_LANES; i++) begin
			if (in_v[i]) begin
				nv++;
				if (in_rd[i] != '0)
					need++;
			end
		end
		return !dispatch_stall && (fl_q.size() >= need) && ((`RN_ROB_DEPTH - rob_q.size()) >= nv);
	endfunction

	// Renames lanes one after another against the live table, which gives
	// the in-group forwarding for free
	function automatic void rename_group(input logic acc, output pipe_reg_t grp [`RN_LANES]);
		int t;
		t = 0;
		for (int i = 0; i < `RN_LANES; i++) begin
			grp[i] = '0;
			grp[i].v = in_v[i] && acc;
			grp[i].pc = in_pc[i];
			grp[i].ard = in_rd[i];
			grp[i].ars1 = in_rs1[i];
			grp[i].ars2 = in_rs2[i];
			if (grp[i].v) begin
				grp[i].ps1 = amap[in_rs1[i]];
				grp[i].ps2 = amap[in_rs2[i]];
				grp[i].pd_old = amap[in_rd[i]];
				grp[i].tag = tail + rob_tag_t'(t);
				t++;
				if (in_rd[i] != '0) begin
					grp[i].pd = fl_q.pop_front();
					amap[in_rd[i]] = grp[i].pd;
				end
				rob_q.push_back(grp[i].pd_old);
			end
		end
		tail = tail + rob_tag_t'(t);
	endfunction

	always @(posedge clk) begin : model_step
		pipe_reg_t grp [`RN_LANES];
		logic      acc;
		if (rst) begin
			fl_q.delete();
			rob_q.delete();
			for (int r = 0; r < `RN_AREGS; r++)
				amap[r] = preg_t'(r);
			for (int r = `RN_AREGS; r < `RN_PREGS; r++)
				fl_q.push_back(preg_t'(r));
			tail = '0;
			for (int i = 0; i < `RN_LANES; i++) begin
				ren_exp[i] = reset_rec();
				que_exp[i] = reset_rec();
			end
			ren_uc = 1'b0;
			que_uc_exp = 1'b0;
		end else begin
			acc = exp_ready() && (|in_v);
			rename_group(acc, grp);
			// Commits free ROB entries and return whatever register was driven
			for (int i = 0; i < `RN_LANES; i++) begin
				if (commit_v[i]) begin
					void'(rob_q.pop_front());
					if (commit_old_pd[i] != '0)
						fl_q.push_back(commit_old_pd[i]);
				end
			end
			if (!dispatch_stall) begin
				for (int i = 0; i < `RN_LANES; i++) begin
					if (ren_exp[i].v)
						que_exp[i] = ren_exp[i];
				end
				que_uc_exp = ren_uc;
				ren_exp = grp;
				ren_uc = ucode_active;
			end
		end
	end

	// ======================================================================
	// Compare tasks and the checking process
	// ======================================================================

	task automatic check_rec(input string name, input pipe_reg_t got, input pipe_reg_t exp);
		if (got !== exp) begin
			$display("Mismatch %s got %h expected %h", name, got, exp);
			mismatches++;
		end
	endtask

	task automatic check_count(input string name, input logic [4:0] got, input logic [4:0] exp);
		if (got !== exp) begin
			$display("Mismatch %s got %h expected %h", name, got, exp);
			mismatches++;
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Mismatch %s got %h expected %h", name, got, exp);
			mismatches++;
		end
	endtask

	// Outputs are settled by the falling edge
	always @(negedge clk) begin
		if (!rst) begin
			for (int i = 0; i < `RN_LANES; i++)
				check_rec($sformatf("que_rec[%0d]", i), que_rec[i], que_exp[i]);
			check_bit("que_ucode", que_ucode, que_uc_exp);
			check_bit("in_ready", in_ready, exp_ready());
			check_count("rob_count", rob_count, 5'(rob_q.size()));
		end
	end

	// ======================================================================
	// Stimulus
	// ======================================================================

	// One cycle of inputs. Committed old registers go through held_q, and with
	// hold set they are kept back so that the free list runs dry
	task automatic drive(input logic [`RN_LANES-1:0] v, input int rd_min, input int rd_max,
			input int ncommit, input logic hold, input logic stall);
		@(posedge clk);
		#1;
		in_v = v;
		for (int i = 0; i < `RN_LANES; i++) begin
			in_pc[i] = $urandom & 32'hFFFF_FFFC;
			// Small register range so lanes often depend on each other
			in_rd[i] = areg_t'($urandom_range(rd_max, rd_min));
			in_rs1[i] = areg_t'($urandom_range(7, 0));
			in_rs2[i] = areg_t'($urandom_range(7, 0));
			commit_v[i] = 1'b0;
			commit_old_pd[i] = '0;
			if (i < ncommit && i < rob_q.size()) begin
				commit_v[i] = 1'b1;
				held_q.push_back(rob_q[i]);
				if (!hold)
					commit_old_pd[i] = held_q.pop_front();
			end
		end
		ucode_active = 1'($urandom);
		dispatch_stall = stall;
	endtask

	// Drives full groups until in_ready reaches the wanted level
	task automatic run_until_ready(input logic level, input int rd_min, input int rd_max,
			input int ncommit, input logic hold, input int limit, input string what);
		int n;
		n = 0;
		do begin
			drive(4'hF, rd_min, rd_max, ncommit, hold, 1'b0);
			@(negedge clk);
			n++;
		end while (in_ready !== level && n < limit);
		if (in_ready !== level) begin
			$display("Timeout: in_ready never went %0d while %s", level, what);
			failures++;
		end
	endtask

	initial begin
		void'($urandom(32'h2d94183b));
		mismatches = 0;
		failures = 0;
		rst = 1'b1;
		in_v = '0;
		ucode_active = 1'b0;
		dispatch_stall = 1'b0;
		commit_v = '0;
		for (int i = 0; i < `RN_LANES; i++) begin
			in_pc[i] = '0;
			in_rd[i] = '0;
			in_rs1[i] = '0;
			in_rs2[i] = '0;
			commit_old_pd[i] = '0;
		end
		repeat (3) @(posedge clk);
		#1;
		rst = 1'b0;
		// Reset values are checked on the first idle cycles
		drive(4'h0, 0, 7, 0, 1'b0, 1'b0);
		// Random groups with commits keeping up
		repeat (60)
			drive(4'($urandom), 0, 7, int'($urandom_range(4, 0)), 1'b0, 1'b0);
		// Some lanes idle while others move on
		drive(4'b1011, 0, 7, 2, 1'b0, 1'b0);
		drive(4'b0100, 0, 7, 2, 1'b0, 1'b0);
		// Empty the reorder buffer so that every free register is back in the list
		repeat (4)
			drive(4'h0, 0, 7, 4, 1'b0, 1'b0);
		// Free-list exhaustion then recovery through returned registers
		// Commits lag allocation so ROB entries remain to return the held registers
		run_until_ready(1'b0, 1, 7, 3, 1'b1, 40, "draining the free list");
		run_until_ready(1'b1, 1, 7, 4, 1'b0, 10, "returning old registers");
		// ROB fill then drain, with destinations on register 0 so no register is taken
		run_until_ready(1'b0, 0, 0, 0, 1'b0, 20, "filling the reorder buffer");
		run_until_ready(1'b1, 0, 0, 2, 1'b0, 20, "committing ROB entries");
		// Stall with commits still flowing
		repeat (5)
			drive(4'hF, 0, 7, 1, 1'b0, 1'b1);
		repeat (6)
			drive(4'($urandom), 0, 7, 2, 1'b0, 1'b0);
		repeat (4)
			drive(4'h0, 0, 7, 4, 1'b0, 1'b0);
		@(negedge clk);
		$display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
		if (mismatches == 0 && failures == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

// ==== flist.f ====
+incdir+design
design/rn_pkg.sv
design/free_list.sv
design/rob_alloc.sv
design/rename_map.sv
design/pipeline_que.sv
design/rename_top.sv
sim/rename_tb.sv

// ==== Makefile ====
# Verilator flow for the rename slice
# Override any variable on the command line, e.g. make sim LOG=run2.log

VERILATOR ?= verilator
FLIST     ?= flist.f
TB_TOP    ?= rename_tb
RTL_TOP   ?= rename_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(RTL_TOP)

$(BUILD_DIR)/V$(TB_TOP): $(FLIST) design/*.sv design/*.svh sim/*.sv
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TB_TOP)
	./$(BUILD_DIR)/V$(TB_TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q '\*\* FAIL \*\*' $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q '\*\* PASS \*\*' $(LOG) || (echo "no pass line in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
